// ==== uart_pkg.sv ====
package uart_pkg;

   // Serial frame geometry.
   localparam int DATA_W     = 8;
   localparam int CMD_W      = 16;
   localparam int FRAME_BITS = 11;            // Start, data, parity, stop.

   // Bit period in clocks.
   localparam int DIV_W = 16;
   localparam logic [DIV_W-1:0] DEFAULT_BAUD_DIV = 16'd16;
   localparam logic [DIV_W-1:0] MIN_BAUD_DIV     = 16'd4;

   // Register map.
   localparam int CFG_ADDR_W = 2;
   localparam logic [CFG_ADDR_W-1:0] REG_DIV    = 2'd0;
   localparam logic [CFG_ADDR_W-1:0] REG_CTRL   = 2'd1;
   localparam logic [CFG_ADDR_W-1:0] REG_STATUS = 2'd2;

   // Live configuration seen by both directions.
   typedef struct packed {
      logic [DIV_W-1:0] baud_div;             // Clocks per bit.
      logic             parity_odd;           // 1 selects odd parity.
   } uart_cfg_t;

   // One received frame.
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              parity_err;          // Parity or stop bit bad.
   } rx_byte_t;

   // Frame parity bit for a given sense.
   function automatic logic frame_parity(
      input logic [DATA_W-1:0] data,
      input logic              odd
   );
      return (^data) ^ odd;
   endfunction

endpackage

// ==== uart_cfg_regs.sv ====
`timescale 1ns/1ps

module uart_cfg_regs
   import uart_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cfg_we,
   input  logic [CFG_ADDR_W-1:0] cfg_addr,
   input  logic [DIV_W-1:0]      cfg_wdata,
   output logic [DIV_W-1:0]      cfg_rdata,
   output uart_cfg_t             cfg,
   input  logic                  rx_strobe,
   input  logic                  rx_parity_err
);

   uart_cfg_t cfg_q;
   logic      err_q;
   logic      wr_div;
   logic      wr_ctrl;
   logic      wr_status;

   assign wr_div    = cfg_we && (cfg_addr == REG_DIV);
   assign wr_ctrl   = cfg_we && (cfg_addr == REG_CTRL);
   assign wr_status = cfg_we && (cfg_addr == REG_STATUS);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cfg_q.baud_div   <= DEFAULT_BAUD_DIV;
         cfg_q.parity_odd <= 1'b1;
      end
      else
      begin
         if (wr_div)
         begin
            // Too short a period would break the mid-bit sampling.
            if (cfg_wdata < MIN_BAUD_DIV)
               cfg_q.baud_div <= MIN_BAUD_DIV;
            else
               cfg_q.baud_div <= cfg_wdata;
         end
         if (wr_ctrl)
            cfg_q.parity_odd <= cfg_wdata[0];
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         err_q <= 1'b0;
      else if (rx_strobe && rx_parity_err)
         err_q <= 1'b1;                       // New error beats a clear.
      else if (wr_status)
         err_q <= 1'b0;
   end

   always_comb
   begin
      cfg_rdata = '0;
      case (cfg_addr)
         REG_DIV:    cfg_rdata = cfg_q.baud_div;
         REG_CTRL:   cfg_rdata[0] = cfg_q.parity_odd;
         REG_STATUS: cfg_rdata[0] = err_q;
         default:    cfg_rdata = '0;
      endcase
   end

   assign cfg = cfg_q;

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
   import uart_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   input  uart_cfg_t        cfg,
   input  logic [CMD_W-1:0] cmd_in,
   input  logic             cmd_vld,
   output logic             cmd_rdy,
   output logic             tx
);

   localparam int IMG_W = 2 * FRAME_BITS;

   logic [DATA_W-1:0] byte_hi;
   logic [DATA_W-1:0] byte_lo;
   logic [IMG_W-1:0]  image;
   logic [IMG_W-1:0]  shreg;
   logic [DIV_W-1:0]  div_q;
   logic [DIV_W-1:0]  cnt;
   logic [4:0]        bit_idx;
   logic              busy;
   logic              accept;
   logic              bit_end;
   logic              last_bit;

   assign byte_hi = cmd_in[CMD_W-1:DATA_W];
   assign byte_lo = cmd_in[DATA_W-1:0];

   // Both frames, high byte first, MSB of each byte first.
   assign image = {1'b0, byte_hi, frame_parity(byte_hi, cfg.parity_odd), 1'b1,
                   1'b0, byte_lo, frame_parity(byte_lo, cfg.parity_odd), 1'b1};

   assign accept   = cmd_vld && !busy;
   assign bit_end  = (cnt == '0);
   assign last_bit = (bit_idx == 5'(IMG_W - 1));
   assign cmd_rdy  = !busy;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy    <= 1'b0;
         tx      <= 1'b1;
         cnt     <= '0;
         bit_idx <= '0;
      end
      else if (accept)
      begin
         busy    <= 1'b1;
         tx      <= image[IMG_W-1];           // Start bit of the high frame.
         cnt     <= cfg.baud_div - 1'b1;
         bit_idx <= '0;
      end
      else if (busy)
      begin
         if (bit_end)
         begin
            if (last_bit)
            begin
               busy <= 1'b0;
               tx   <= 1'b1;
            end
            else
            begin
               tx      <= shreg[IMG_W-1];
               cnt     <= div_q - 1'b1;
               bit_idx <= bit_idx + 1'b1;
            end
         end
         else
         begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   // Frame image and period, taken at acceptance.
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         shreg <= {image[IMG_W-2:0], 1'b1};
         div_q <= cfg.baud_div;
      end
      else if (busy && bit_end)
      begin
         shreg <= {shreg[IMG_W-2:0], 1'b1};
      end
   end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
   import uart_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  uart_cfg_t cfg,
   input  logic      rx,
   output logic      rx_strobe,
   output rx_byte_t  rx_byte
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_START,
      ST_DATA,
      ST_PARITY,
      ST_STOP
   } rx_state_t;

   rx_state_t         state;
   logic              rx_s1;
   logic              rx_s2;
   logic              rx_d;
   logic [DIV_W-1:0]  cnt;
   logic [2:0]        bit_cnt;
   logic [DATA_W-1:0] shreg;
   logic              par_bit;
   logic              sample;
   logic              par_bad;

   assign sample  = (cnt == '0);
   assign par_bad = (par_bit != frame_parity(shreg, cfg.parity_odd));

   // Two flops for the async line plus one for edge detection.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rx_s1 <= 1'b1;
         rx_s2 <= 1'b1;
         rx_d  <= 1'b1;
      end
      else
      begin
         rx_s1 <= rx;
         rx_s2 <= rx_s1;
         rx_d  <= rx_s2;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= ST_IDLE;
         cnt       <= '0;
         bit_cnt   <= '0;
         rx_strobe <= 1'b0;
         rx_byte   <= '0;
      end
      else
      begin
         rx_strobe <= 1'b0;
         if (state != ST_IDLE)
            cnt <= sample ? cfg.baud_div - 1'b1 : cnt - 1'b1;
         case (state)
            ST_IDLE:
               if (rx_d && !rx_s2)
               begin
                  state <= ST_START;
                  cnt   <= (cfg.baud_div >> 1) - 1'b1;   // Half a bit.
               end
            ST_START:
               if (sample)
               begin
                  state   <= rx_s2 ? ST_IDLE : ST_DATA;  // High here is a glitch.
                  bit_cnt <= '0;
               end
            ST_DATA:
               if (sample)
               begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'(DATA_W - 1))
                     state <= ST_PARITY;
               end
            ST_PARITY:
               if (sample)
                  state <= ST_STOP;
            ST_STOP:
               if (sample)
               begin
                  state              <= ST_IDLE;
                  rx_strobe          <= 1'b1;
                  rx_byte.data       <= shreg;
                  rx_byte.parity_err <= par_bad || !rx_s2;  // Low stop counts too.
               end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // Data and parity capture.
   always_ff @(posedge clk)
   begin
      if (sample && state == ST_DATA)
         shreg <= {shreg[DATA_W-2:0], rx_s2};
      if (sample && state == ST_PARITY)
         par_bit <= rx_s2;
   end

endmodule

// ==== uart_top.sv ====
`timescale 1ns/1ps

module uart_top
   import uart_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [CMD_W-1:0]      cmd_in,
   input  logic                  cmd_vld,
   output logic                  cmd_rdy,
   output logic                  tx,
   input  logic                  rx,
   output logic                  read_rdy,
   output logic [DATA_W-1:0]     read_data,
   input  logic                  cfg_we,
   input  logic [CFG_ADDR_W-1:0] cfg_addr,
   input  logic [DIV_W-1:0]      cfg_wdata,
   output logic [DIV_W-1:0]      cfg_rdata
);

   uart_cfg_t cfg;
   rx_byte_t  rx_byte;
   logic      rx_strobe;

   uart_cfg_regs cfg0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .cfg_we        (cfg_we),
      .cfg_addr      (cfg_addr),
      .cfg_wdata     (cfg_wdata),
      .cfg_rdata     (cfg_rdata),
      .cfg           (cfg),
      .rx_strobe     (rx_strobe),
      .rx_parity_err (rx_byte.parity_err)
   );

   uart_tx tx0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .cfg     (cfg),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   uart_rx rx0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg       (cfg),
      .rx        (rx),
      .rx_strobe (rx_strobe),
      .rx_byte   (rx_byte)
   );

   assign read_rdy  = rx_strobe;
   assign read_data = rx_byte.data;          // Held until the next strobe.

endmodule

// ==== uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb
   import uart_pkg::*;
();

   localparam int CMD_COUNT       = 12;
   localparam int MAX_DIV         = 16;
   localparam int WATCHDOG_CYCLES = CMD_COUNT * 2 * FRAME_BITS * MAX_DIV + 2000;

   logic                  clk;
   logic                  rst_n;
   logic [CMD_W-1:0]      cmd_in;
   logic                  cmd_vld;
   logic                  cmd_rdy;
   logic                  tx;
   logic                  rx_line;
   logic                  read_rdy;
   logic [DATA_W-1:0]     read_data;
   logic                  cfg_we;
   logic [CFG_ADDR_W-1:0] cfg_addr;
   logic [DIV_W-1:0]      cfg_wdata;
   logic [DIV_W-1:0]      cfg_rdata;
   logic                  drive_sel;              // Low loops tx back to rx.
   logic                  drv_line;
   logic [DATA_W-1:0]     rx_q[$];
   integer                seed = 32'h69626587;
   int                    err_cnt = 0;
   int                    tests_run = 0;
   int                    tests_bad = 0;

   assign rx_line = drive_sel ? drv_line : tx;

   uart_top dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .tx        (tx),
      .rx        (rx_line),
      .read_rdy  (read_rdy),
      .read_data (read_data),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("tests failed");
      $finish;
   end

   // Collect every received byte.
   always @(negedge clk)
   begin
      if (read_rdy)
         rx_q.push_back(read_data);
   end

   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   task automatic check_val(input string name, input logic [15:0] act,
                            input logic [15:0] exp);
      if (act !== exp)
      begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic report_error(input string what);
      $display("%s", what);
      err_cnt++;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      if (err_cnt == errs_before)
         $display("%s: ok", name);
      else
      begin
         $display("%s: %0d errors", name, err_cnt - errs_before);
         tests_bad++;
      end
   endtask

   function automatic logic expected_parity(input logic [7:0] b, input logic odd);
      int ones;
      ones = 0;
      for (int i = 0; i < DATA_W; i++)
         ones += b[i];
      if (odd)
         return (ones % 2) == 0;
      else
         return (ones % 2) == 1;
   endfunction

   // Bit idx of one frame, start bit first.
   function automatic logic frame_bit(input logic [7:0] b, input logic odd, input int idx);
      if (idx == 0)
         return 1'b0;
      else if (idx <= DATA_W)
         return b[DATA_W - idx];
      else if (idx == DATA_W + 1)
         return expected_parity(b, odd);
      else
         return 1'b1;
   endfunction

   function automatic logic line_bit(input logic [15:0] c, input logic odd, input int k);
      if (k < FRAME_BITS)
         return frame_bit(c[15:8], odd, k);
      else
         return frame_bit(c[7:0], odd, k - FRAME_BITS);
   endfunction

   task automatic write_reg(input logic [CFG_ADDR_W-1:0] addr, input logic [15:0] data);
      cfg_addr  = addr;
      cfg_wdata = data;
      cfg_we    = 1'b1;
      next_cycle();
      cfg_we    = 1'b0;
   endtask

   task automatic read_check(input logic [CFG_ADDR_W-1:0] addr, input logic [15:0] exp,
                             input string name);
      cfg_addr = addr;
      #1;
      check_val(name, cfg_rdata, exp);
   endtask

   task automatic wait_rdy(input int limit);
      int n;
      n = 0;
      while (!cmd_rdy && n < limit)
      begin
         next_cycle();
         n++;
      end
      if (!cmd_rdy)
         report_error("cmd_rdy stayed low past its timeout");
   endtask

   task automatic send_cmd(input logic [15:0] c, input int div);
      wait_rdy(2 * FRAME_BITS * div + 10);
      cmd_in  = c;
      cmd_vld = 1'b1;
      next_cycle();                               // Acceptance edge.
      cmd_vld = 1'b0;
   endtask

   task automatic wait_bytes(input int count, input int limit);
      int n;
      n = 0;
      while (rx_q.size() < count && n < limit)
      begin
         next_cycle();
         n++;
      end
      if (rx_q.size() < count)
         $display("receiver gave %0d of %0d bytes before timeout", rx_q.size(), count);
      if (rx_q.size() < count)
         err_cnt++;
   endtask

   task automatic check_pair(input logic [7:0] hi, input logic [7:0] lo, input int limit);
      logic [7:0] got;
      wait_bytes(2, limit);
      if (rx_q.size() >= 2)
      begin
         got = rx_q.pop_front();
         check_val("read_data", got, hi);
         got = rx_q.pop_front();
         check_val("read_data", got, lo);
      end
   endtask

   task automatic drive_frame(input logic [7:0] b, input logic par, input logic stop,
                              input int div);
      for (int k = 0; k < FRAME_BITS; k++)
      begin
         if (k == 0)
            drv_line = 1'b0;
         else if (k <= DATA_W)
            drv_line = b[DATA_W - k];
         else if (k == DATA_W + 1)
            drv_line = par;
         else
            drv_line = stop;
         repeat (div) next_cycle();
      end
      drv_line = 1'b1;
      repeat (2 * div) next_cycle();              // Idle gap.
   endtask

   task automatic test_reset();
      int e0;
      e0 = err_cnt;
      check_val("tx", tx, 1'b1);
      check_val("cmd_rdy", cmd_rdy, 1'b1);
      check_val("read_rdy", read_rdy, 1'b0);
      check_val("read_data", read_data, 8'h00);
      read_check(REG_DIV, 16'd16, "cfg_rdata div");
      read_check(REG_CTRL, 16'd1, "cfg_rdata ctrl");
      read_check(REG_STATUS, 16'd0, "cfg_rdata status");
      finish_test("reset_state", e0);
   endtask

   task automatic test_regs();
      int e0;
      e0 = err_cnt;
      write_reg(REG_DIV, 16'd100);
      read_check(REG_DIV, 16'd100, "cfg_rdata div");
      write_reg(REG_CTRL, 16'd0);
      read_check(REG_CTRL, 16'd0, "cfg_rdata ctrl");
      write_reg(REG_CTRL, 16'd1);
      read_check(REG_CTRL, 16'd1, "cfg_rdata ctrl");
      write_reg(REG_DIV, 16'd3);
      read_check(REG_DIV, 16'd4, "cfg_rdata div");  // Clamped up.
      write_reg(REG_DIV, 16'd0);
      read_check(REG_DIV, 16'd4, "cfg_rdata div");
      read_check(2'd3, 16'd0, "cfg_rdata unused");
      write_reg(REG_DIV, 16'd16);
      finish_test("register_access", e0);
   endtask

   task automatic test_framing();
      int          e0;
      int          div;
      logic [15:0] c;
      e0  = err_cnt;
      div = 8;
      c   = 16'hC35A;
      write_reg(REG_DIV, 16'(div));
      rx_q.delete();
      send_cmd(c, div);
      for (int n = 0; n < 2 * FRAME_BITS * div; n++)
      begin
         check_val("cmd_rdy", cmd_rdy, 1'b0);
         if (n % div == div / 2)
            check_val("tx", tx, line_bit(c, 1'b1, n / div));  // Mid-bit.
         next_cycle();
      end
      check_val("cmd_rdy", cmd_rdy, 1'b1);
      check_val("tx", tx, 1'b1);
      check_pair(c[15:8], c[7:0], 4 * div);
      finish_test("tx_framing", e0);
   endtask

   task automatic test_loopback();
      int          e0;
      int          div;
      logic [15:0] c;
      e0 = err_cnt;
      rx_q.delete();
      for (int p = 0; p < 2; p++)
      begin
         for (int d = 0; d < 2; d++)
         begin
            div = (d == 0) ? 8 : 16;
            write_reg(REG_CTRL, 16'(p));
            write_reg(REG_DIV, 16'(div));
            for (int k = 0; k < 2; k++)
            begin
               c = 16'($random(seed));
               send_cmd(c, div);
               check_pair(c[15:8], c[7:0], 2 * FRAME_BITS * div + 20);
            end
         end
      end
      wait_rdy(4 * MAX_DIV);
      read_check(REG_STATUS, 16'd0, "cfg_rdata status");
      finish_test("loopback", e0);
   endtask

   task automatic test_parity_err();
      int e0;
      int div;
      e0  = err_cnt;
      div = 8;
      write_reg(REG_DIV, 16'(div));
      write_reg(REG_CTRL, 16'd0);
      rx_q.delete();
      drive_sel = 1'b1;
      drive_frame(8'hA5, ~expected_parity(8'hA5, 1'b0), 1'b1, div);
      wait_bytes(1, 4 * div);
      read_check(REG_STATUS, 16'd1, "cfg_rdata status");
      write_reg(REG_STATUS, 16'd0);
      read_check(REG_STATUS, 16'd0, "cfg_rdata status");
      drive_frame(8'h3C, expected_parity(8'h3C, 1'b0), 1'b0, div);  // Low stop bit.
      check_pair(8'hA5, 8'h3C, 4 * div);
      read_check(REG_STATUS, 16'd1, "cfg_rdata status");
      write_reg(REG_STATUS, 16'd0);
      read_check(REG_STATUS, 16'd0, "cfg_rdata status");
      drive_sel = 1'b0;
      finish_test("parity_errors", e0);
   endtask

   task automatic test_backpressure();
      int          e0;
      int          div;
      logic [15:0] a;
      e0  = err_cnt;
      div = 8;
      a   = 16'($random(seed));
      write_reg(REG_DIV, 16'(div));
      rx_q.delete();
      send_cmd(a, div);
      repeat (3) next_cycle();
      cmd_in  = ~a;
      cmd_vld = 1'b1;
      for (int n = 0; n < 10; n++)
      begin
         check_val("cmd_rdy", cmd_rdy, 1'b0);
         next_cycle();
      end
      cmd_vld = 1'b0;
      check_pair(a[15:8], a[7:0], 2 * FRAME_BITS * div + 20);
      wait_rdy(4 * div);
      repeat (2 * FRAME_BITS * div) next_cycle();
      if (rx_q.size() != 0)
         report_error("bytes of the dropped command arrived");
      check_val("cmd_rdy", cmd_rdy, 1'b1);
      finish_test("back_pressure", e0);
   endtask

   initial
   begin
      rst_n     = 1'b0;
      cmd_in    = '0;
      cmd_vld   = 1'b0;
      cfg_we    = 1'b0;
      cfg_addr  = '0;
      cfg_wdata = '0;
      drive_sel = 1'b0;
      drv_line  = 1'b1;
      repeat (3) @(posedge clk);
      #10;
      rst_n = 1'b1;
      test_reset();
      test_regs();
      test_framing();
      test_loopback();
      test_parity_err();
      test_backpressure();
      $display("summary: %0d run, %0d with errors, %0d check errors",
               tests_run, tests_bad, err_cnt);
      if (err_cnt == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== compile.f ====
uart_pkg.sv
uart_cfg_regs.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart_subsystem

sources:
  - uart_pkg.sv
  - uart_cfg_regs.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_top.sv
  - target: simulation
    files:
      - uart_tb.sv
